/* logic/agu_pkg.sv */
// Shared definitions for the tiled address generator
// Widths, null address, mode and stream encodings, configuration structs

package agu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ADDR_W = 32;
    localparam int IDX_W  = 16;

    // Placed on every out-of-tile or padding position
    localparam logic [ADDR_W-1:0] NULL_ADDR = {ADDR_W{1'b1}};

    // Codes 0 and 2 are legacy conv modes, run as matrix multiply
    typedef enum logic [1:0] {
        OP_REGULAR   = 2'd0,
        OP_POINTWISE = 2'd1,
        OP_DEPTHWISE = 2'd2,
        OP_MATMUL    = 2'd3
    } op_mode_e;

    typedef enum logic [1:0] {
        STRM_A = 2'd0,
        STRM_B = 2'd1,
        STRM_C = 2'd2
    } stream_id_e;

    // ------------------------------
    // Configuration
    // ------------------------------
    typedef struct packed {
        logic [IDX_W-1:0] i_tile;
        logic [IDX_W-1:0] j_tile;
        logic [IDX_W-1:0] k_tile;
        logic [IDX_W-1:0] etm;
        logic [IDX_W-1:0] etn;
        logic [IDX_W-1:0] etk;
        logic [IDX_W-1:0] tm;
        logic [IDX_W-1:0] tn;
        logic [IDX_W-1:0] tk;
        logic [IDX_W-1:0] mat_k;
        logic [IDX_W-1:0] mat_n;
    } tile_cfg_t;

    // out_w is derived once at the top level
    typedef struct packed {
        logic [IDX_W-1:0] act_h;
        logic [IDX_W-1:0] act_w;
        logic [IDX_W-1:0] act_cin;
        logic [IDX_W-1:0] padding;
        logic [IDX_W-1:0] stride;
        logic [IDX_W-1:0] out_w;
    } conv_cfg_t;

endpackage

/* logic/agu_stream_if.sv */
// Address stream from one generator to the port arbiter
// Arbiter pulls with advance, generator presents the current position

`timescale 1ns/1ps

interface agu_stream_if #(
    parameter int ADDR_W = agu_pkg::ADDR_W
) ();

    // One position consumed per high cycle
    logic              advance;
    logic [ADDR_W-1:0] addr;
    logic              is_null;
    // Final position of this stream in the tile
    logic              last;

    modport gen (
        input  advance,
        output addr,
        output is_null,
        output last
    );

    modport arb (
        output advance,
        input  addr,
        input  is_null,
        input  last
    );

endinterface

/* logic/tile_idx_counter.sv */
// Two-level nested tile index counter
// Inner index runs fastest, both wrap to zero after the last position

`timescale 1ns/1ps

module tile_idx_counter #(
    parameter int IDX_W = agu_pkg::IDX_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_step,
    input  logic [IDX_W-1:0] i_inner_size,
    input  logic [IDX_W-1:0] i_outer_size,
    input  logic [IDX_W-1:0] i_inner_base,
    input  logic [IDX_W-1:0] i_outer_base,
    output logic [IDX_W-1:0] o_inner_local,
    output logic [IDX_W-1:0] o_outer_local,
    output logic [IDX_W-1:0] o_inner_global,
    output logic [IDX_W-1:0] o_outer_global,
    output logic             o_last
);

    logic [IDX_W-1:0] inner_cnt;
    logic [IDX_W-1:0] outer_cnt;
    logic             inner_wrap;

    assign inner_wrap = (inner_cnt == i_inner_size - IDX_W'(1));
    assign o_last     = inner_wrap && (outer_cnt == i_outer_size - IDX_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inner_cnt <= '0;
            outer_cnt <= '0;
        end else if (i_step) begin
            if (inner_wrap) begin
                inner_cnt <= '0;
                // Back to origin for the next tile
                if (o_last) begin
                    outer_cnt <= '0;
                end else begin
                    outer_cnt <= outer_cnt + IDX_W'(1);
                end
            end else begin
                inner_cnt <= inner_cnt + IDX_W'(1);
            end
        end
    end

    assign o_inner_local  = inner_cnt;
    assign o_outer_local  = outer_cnt;
    assign o_inner_global = i_inner_base + inner_cnt;
    assign o_outer_global = i_outer_base + outer_cnt;

endmodule

/* logic/act_addr_gen.sv */
// A-stream generator, matrix A or HWC activation addresses
// k runs fastest over tk, i over tm; out-of-tile and padding give null

`timescale 1ns/1ps

module act_addr_gen #(
    parameter int ADDR_W = agu_pkg::ADDR_W,
    parameter int IDX_W  = agu_pkg::IDX_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  agu_pkg::op_mode_e   i_mode,
    input  logic [ADDR_W-1:0]   i_base,
    input  agu_pkg::tile_cfg_t  i_tile,
    input  agu_pkg::conv_cfg_t  i_conv,
    agu_stream_if.gen           o_strm
);

    import agu_pkg::*;

    // Signed width wide enough for out_h * stride - padding
    localparam int SW = 2 * IDX_W + 1;

    logic [IDX_W-1:0]     k_loc;
    logic [IDX_W-1:0]     i_loc;
    logic [IDX_W-1:0]     k_glb;
    logic [IDX_W-1:0]     i_glb;
    logic [IDX_W-1:0]     out_h;
    logic [IDX_W-1:0]     out_w;
    logic signed [SW-1:0] in_h;
    logic signed [SW-1:0] in_w;
    logic                 in_pad;
    logic                 out_of_tile;
    logic [ADDR_W-1:0]    pix_idx;

    tile_idx_counter #(
        .IDX_W (IDX_W)
    ) u_cnt (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_step         (o_strm.advance),
        .i_inner_size   (i_tile.tk),
        .i_outer_size   (i_tile.tm),
        .i_inner_base   (i_tile.k_tile),
        .i_outer_base   (i_tile.i_tile),
        .o_inner_local  (k_loc),
        .o_outer_local  (i_loc),
        .o_inner_global (k_glb),
        .o_outer_global (i_glb),
        .o_last         (o_strm.last)
    );

    // ------------------------------
    // Pointwise input position
    // ------------------------------
    assign out_h = i_glb / i_conv.out_w;
    assign out_w = i_glb % i_conv.out_w;

    // Negative when the window starts in the top or left padding
    assign in_h = $signed(SW'(out_h) * SW'(i_conv.stride)) - $signed(SW'(i_conv.padding));
    assign in_w = $signed(SW'(out_w) * SW'(i_conv.stride)) - $signed(SW'(i_conv.padding));

    assign in_pad = (in_h < 0) || (in_h >= $signed(SW'(i_conv.act_h))) ||
                    (in_w < 0) || (in_w >= $signed(SW'(i_conv.act_w)));

    // HWC pixel index, only used when not in padding
    assign pix_idx = ADDR_W'(in_h) * ADDR_W'(i_conv.act_w) + ADDR_W'(in_w);

    assign out_of_tile = (i_loc >= i_tile.etm) || (k_loc >= i_tile.etk);

    always_comb begin
        o_strm.addr    = ADDR_W'(NULL_ADDR);
        o_strm.is_null = 1'b1;
        if (!out_of_tile) begin
            if (i_mode == OP_POINTWISE) begin
                if (!in_pad) begin
                    o_strm.addr    = i_base + pix_idx * ADDR_W'(i_conv.act_cin) +
                                     ADDR_W'(k_glb);
                    o_strm.is_null = 1'b0;
                end
            end else begin
                // Row-major A, row length K
                o_strm.addr    = i_base + ADDR_W'(i_glb) * ADDR_W'(i_tile.mat_k) +
                                 ADDR_W'(k_glb);
                o_strm.is_null = 1'b0;
            end
        end
    end

endmodule

/* logic/ker_addr_gen.sv */
// B-stream generator, matrix B or pointwise kernel addresses
// k runs fastest over tk, j over tn

`timescale 1ns/1ps

module ker_addr_gen #(
    parameter int ADDR_W = agu_pkg::ADDR_W,
    parameter int IDX_W  = agu_pkg::IDX_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  agu_pkg::op_mode_e   i_mode,
    input  logic [ADDR_W-1:0]   i_base,
    input  agu_pkg::tile_cfg_t  i_tile,
    input  logic [IDX_W-1:0]    i_act_cin,
    agu_stream_if.gen           o_strm
);

    import agu_pkg::*;

    logic [IDX_W-1:0] k_loc;
    logic [IDX_W-1:0] j_loc;
    logic [IDX_W-1:0] k_glb;
    logic [IDX_W-1:0] j_glb;

    tile_idx_counter #(
        .IDX_W (IDX_W)
    ) u_cnt (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_step         (o_strm.advance),
        .i_inner_size   (i_tile.tk),
        .i_outer_size   (i_tile.tn),
        .i_inner_base   (i_tile.k_tile),
        .i_outer_base   (i_tile.j_tile),
        .o_inner_local  (k_loc),
        .o_outer_local  (j_loc),
        .o_inner_global (k_glb),
        .o_outer_global (j_glb),
        .o_last         (o_strm.last)
    );

    always_comb begin
        if ((j_loc >= i_tile.etn) || (k_loc >= i_tile.etk)) begin
            o_strm.addr    = ADDR_W'(NULL_ADDR);
            o_strm.is_null = 1'b1;
        end else if (i_mode == OP_POINTWISE) begin
            // One kernel row of act_cin weights per output channel
            o_strm.addr    = i_base + ADDR_W'(j_glb) * ADDR_W'(i_act_cin) + ADDR_W'(k_glb);
            o_strm.is_null = 1'b0;
        end else begin
            o_strm.addr    = i_base + ADDR_W'(k_glb) * ADDR_W'(i_tile.mat_n) + ADDR_W'(j_glb);
            o_strm.is_null = 1'b0;
        end
    end

endmodule

/* logic/out_addr_gen.sv */
// C-stream generator, row-major output addresses in every mode

`timescale 1ns/1ps

module out_addr_gen #(
    parameter int ADDR_W = agu_pkg::ADDR_W,
    parameter int IDX_W  = agu_pkg::IDX_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [ADDR_W-1:0]   i_base,
    input  agu_pkg::tile_cfg_t  i_tile,
    agu_stream_if.gen           o_strm
);

    import agu_pkg::*;

    logic [IDX_W-1:0] j_loc;
    logic [IDX_W-1:0] i_loc;
    logic [IDX_W-1:0] j_glb;
    logic [IDX_W-1:0] i_glb;
    logic             in_tile;

    // j runs fastest
    tile_idx_counter #(
        .IDX_W (IDX_W)
    ) u_cnt (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_step         (o_strm.advance),
        .i_inner_size   (i_tile.tn),
        .i_outer_size   (i_tile.tm),
        .i_inner_base   (i_tile.j_tile),
        .i_outer_base   (i_tile.i_tile),
        .o_inner_local  (j_loc),
        .o_outer_local  (i_loc),
        .o_inner_global (j_glb),
        .o_outer_global (i_glb),
        .o_last         (o_strm.last)
    );

    assign in_tile        = (i_loc < i_tile.etm) && (j_loc < i_tile.etn);
    assign o_strm.is_null = !in_tile;
    assign o_strm.addr    = in_tile ?
                            i_base + ADDR_W'(i_glb) * ADDR_W'(i_tile.mat_n) + ADDR_W'(j_glb) :
                            ADDR_W'(NULL_ADDR);

endmodule

/* logic/addr_port_arbiter.sv */
// Tile phase sequencer for the shared address port
// Grants A, B, then C streams and registers the granted address

`timescale 1ns/1ps

module addr_port_arbiter #(
    parameter int ADDR_W = agu_pkg::ADDR_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_start_tile,
    input  logic                i_read_req,
    agu_stream_if.arb           a_strm,
    agu_stream_if.arb           b_strm,
    agu_stream_if.arb           c_strm,
    output logic [ADDR_W-1:0]   o_addr,
    output agu_pkg::stream_id_e o_id,
    output logic                o_valid,
    output logic                o_is_null,
    output logic                o_tile_done,
    output logic                o_ready
);

    import agu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        GRANT_A,
        GRANT_B,
        GRANT_C,
        DONE
    } state_t;

    state_t            state;
    state_t            next_state;
    logic [ADDR_W-1:0] sel_addr;
    logic              sel_null;
    logic              sel_last;
    stream_id_e        sel_id;
    logic              accept;

    // ------------------------------
    // Grant steering
    // ------------------------------
    always_comb begin
        a_strm.advance = 1'b0;
        b_strm.advance = 1'b0;
        c_strm.advance = 1'b0;
        sel_addr       = ADDR_W'(NULL_ADDR);
        sel_null       = 1'b1;
        sel_last       = 1'b0;
        sel_id         = STRM_A;
        accept         = 1'b0;
        case (state)
            GRANT_A: begin
                a_strm.advance = i_read_req;
                sel_addr       = a_strm.addr;
                sel_null       = a_strm.is_null;
                sel_last       = a_strm.last;
                accept         = i_read_req;
            end
            GRANT_B: begin
                b_strm.advance = i_read_req;
                sel_addr       = b_strm.addr;
                sel_null       = b_strm.is_null;
                sel_last       = b_strm.last;
                sel_id         = STRM_B;
                accept         = i_read_req;
            end
            GRANT_C: begin
                c_strm.advance = i_read_req;
                sel_addr       = c_strm.addr;
                sel_null       = c_strm.is_null;
                sel_last       = c_strm.last;
                sel_id         = STRM_C;
                accept         = i_read_req;
            end
            default: ;
        endcase
    end

    // Phase moves on as soon as the last position is taken
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (i_start_tile) next_state = GRANT_A;
            GRANT_A: if (accept && sel_last) next_state = GRANT_B;
            GRANT_B: if (accept && sel_last) next_state = GRANT_C;
            GRANT_C: if (accept && sel_last) next_state = DONE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            o_valid   <= 1'b0;
            o_addr    <= ADDR_W'(NULL_ADDR);
            o_is_null <= 1'b1;
            o_id      <= STRM_A;
        end else begin
            state   <= next_state;
            o_valid <= accept;
            if (accept) begin
                o_addr    <= sel_addr;
                o_is_null <= sel_null;
                o_id      <= sel_id;
            end else begin
                o_addr    <= ADDR_W'(NULL_ADDR);
                o_is_null <= 1'b1;
            end
        end
    end

    // DONE lines up with the registered last C address
    assign o_tile_done = (state == DONE);
    assign o_ready     = (state == IDLE);

endmodule

/* logic/conv_agu_top.sv */
// Tiled address generator top level
// Packs plain config ports and wires three stream generators to the port arbiter

`timescale 1ns/1ps

module conv_agu_top #(
    parameter int ADDR_W = agu_pkg::ADDR_W,
    parameter int IDX_W  = agu_pkg::IDX_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_start_tile,
    input  logic                i_read_req,
    input  agu_pkg::op_mode_e   i_op_mode,
    input  logic [ADDR_W-1:0]   i_base_a,
    input  logic [ADDR_W-1:0]   i_base_b,
    input  logic [ADDR_W-1:0]   i_base_c,
    input  logic [IDX_W-1:0]    i_act_h,
    input  logic [IDX_W-1:0]    i_act_w,
    input  logic [IDX_W-1:0]    i_act_cin,
    input  logic [IDX_W-1:0]    i_padding,
    input  logic [IDX_W-1:0]    i_stride,
    input  logic [IDX_W-1:0]    i_mat_k,
    input  logic [IDX_W-1:0]    i_mat_n,
    input  logic [IDX_W-1:0]    i_i_tile,
    input  logic [IDX_W-1:0]    i_j_tile,
    input  logic [IDX_W-1:0]    i_k_tile,
    input  logic [IDX_W-1:0]    i_etm,
    input  logic [IDX_W-1:0]    i_etn,
    input  logic [IDX_W-1:0]    i_etk,
    input  logic [IDX_W-1:0]    i_tm,
    input  logic [IDX_W-1:0]    i_tn,
    input  logic [IDX_W-1:0]    i_tk,
    output logic [ADDR_W-1:0]   o_addr,
    output agu_pkg::stream_id_e o_id,
    output logic                o_valid,
    output logic                o_is_null,
    output logic                o_tile_done,
    output logic                o_ready
);

    import agu_pkg::*;

    tile_cfg_t        tile_cfg;
    conv_cfg_t        conv_cfg;
    logic [IDX_W-1:0] stride_div;
    logic [IDX_W-1:0] out_w;

    // Stride of zero is only seen in matrix mode
    assign stride_div = (i_stride == '0) ? IDX_W'(1) : i_stride;
    assign out_w      = (i_act_w + (i_padding << 1) - IDX_W'(1)) / stride_div + IDX_W'(1);

    assign tile_cfg = '{i_tile: i_i_tile, j_tile: i_j_tile, k_tile: i_k_tile,
                        etm: i_etm, etn: i_etn, etk: i_etk,
                        tm: i_tm, tn: i_tn, tk: i_tk,
                        mat_k: i_mat_k, mat_n: i_mat_n};

    assign conv_cfg = '{act_h: i_act_h, act_w: i_act_w, act_cin: i_act_cin,
                        padding: i_padding, stride: i_stride, out_w: out_w};

    // ------------------------------
    // Streams and generators
    // ------------------------------
    agu_stream_if #(.ADDR_W(ADDR_W)) a_if ();
    agu_stream_if #(.ADDR_W(ADDR_W)) b_if ();
    agu_stream_if #(.ADDR_W(ADDR_W)) c_if ();

    act_addr_gen #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W)
    ) u_act_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_mode (i_op_mode),
        .i_base (i_base_a),
        .i_tile (tile_cfg),
        .i_conv (conv_cfg),
        .o_strm (a_if)
    );

    ker_addr_gen #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W)
    ) u_ker_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_mode    (i_op_mode),
        .i_base    (i_base_b),
        .i_tile    (tile_cfg),
        .i_act_cin (i_act_cin),
        .o_strm    (b_if)
    );

    out_addr_gen #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W)
    ) u_out_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_base (i_base_c),
        .i_tile (tile_cfg),
        .o_strm (c_if)
    );

    addr_port_arbiter #(
        .ADDR_W (ADDR_W)
    ) u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start_tile (i_start_tile),
        .i_read_req   (i_read_req),
        .a_strm       (a_if),
        .b_strm       (b_if),
        .c_strm       (c_if),
        .o_addr       (o_addr),
        .o_id         (o_id),
        .o_valid      (o_valid),
        .o_is_null    (o_is_null),
        .o_tile_done  (o_tile_done),
        .o_ready      (o_ready)
    );

endmodule

/* include/agu_tb_ref.svh */
// Reference model for the tiled address generator testbench
// Expected address and null flag per stream position, and the stimulus LFSR

`ifndef AGU_TB_REF_SVH
`define AGU_TB_REF_SVH

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] galois_step(input logic [15:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 16'hB400;
    end else begin
        return state >> 1;
    end
endfunction

// ------------------------------
// Expected {is_null, addr} for stream 0 (A), 1 (B) or 2 (C)
// ------------------------------
function automatic logic [32:0] ref_entry(
    input op_mode_e    mode,
    input tile_cfg_t   t,
    input conv_cfg_t   c,
    input logic [31:0] base,
    input int          strm,
    input int          pos
);
    longint row;
    longint col;
    longint ig;
    longint ih;
    longint iw;
    longint outw;
    longint stride;
    longint pad;
    logic   pw;
    pw     = (mode == OP_POINTWISE);
    outw   = c.out_w;
    stride = c.stride;
    pad    = c.padding;
    case (strm)
        0: begin
            // k fastest, i outer
            col = pos % longint'(t.tk);
            row = pos / longint'(t.tk);
            if (row >= longint'(t.etm) || col >= longint'(t.etk)) begin
                return {1'b1, NULL_ADDR};
            end
            ig = longint'(t.i_tile) + row;
            if (!pw) begin
                return {1'b0, 32'(base + ig * longint'(t.mat_k) + longint'(t.k_tile) + col)};
            end
            // Output pixel back to input pixel, negative in padding
            ih = (ig / outw) * stride - pad;
            iw = (ig % outw) * stride - pad;
            if (ih < 0 || ih >= longint'(c.act_h) || iw < 0 || iw >= longint'(c.act_w)) begin
                return {1'b1, NULL_ADDR};
            end
            return {1'b0, 32'(base + (ih * longint'(c.act_w) + iw) * longint'(c.act_cin) +
                              longint'(t.k_tile) + col)};
        end
        1: begin
            // k fastest, j outer
            col = pos % longint'(t.tk);
            row = pos / longint'(t.tk);
            if (row >= longint'(t.etn) || col >= longint'(t.etk)) begin
                return {1'b1, NULL_ADDR};
            end
            if (pw) begin
                return {1'b0, 32'(base + (longint'(t.j_tile) + row) * longint'(c.act_cin) +
                                  longint'(t.k_tile) + col)};
            end
            return {1'b0, 32'(base + (longint'(t.k_tile) + col) * longint'(t.mat_n) +
                              longint'(t.j_tile) + row)};
        end
        default: begin
            // j fastest, i outer
            col = pos % longint'(t.tn);
            row = pos / longint'(t.tn);
            if (row >= longint'(t.etm) || col >= longint'(t.etn)) begin
                return {1'b1, NULL_ADDR};
            end
            return {1'b0, 32'(base + (longint'(t.i_tile) + row) * longint'(t.mat_n) +
                              longint'(t.j_tile) + col)};
        end
    endcase
endfunction

`endif

/* verif/tb_conv_agu.sv */
// Testbench for the tiled address generator
// Runs matrix and pointwise tiles and checks every output against a reference model

`timescale 1ns/1ps

module tb_conv_agu;

    import agu_pkg::*;

    `include "agu_tb_ref.svh"

    localparam int TILE_TIMEOUT  = 2000;
    localparam int READY_TIMEOUT = 50;

    logic                clk;
    logic                rst_n;
    logic                i_start_tile;
    logic                i_read_req;
    op_mode_e            i_op_mode;
    logic [ADDR_W-1:0]   i_base_a;
    logic [ADDR_W-1:0]   i_base_b;
    logic [ADDR_W-1:0]   i_base_c;
    logic [IDX_W-1:0]    i_act_h;
    logic [IDX_W-1:0]    i_act_w;
    logic [IDX_W-1:0]    i_act_cin;
    logic [IDX_W-1:0]    i_padding;
    logic [IDX_W-1:0]    i_stride;
    logic [IDX_W-1:0]    i_mat_k;
    logic [IDX_W-1:0]    i_mat_n;
    logic [IDX_W-1:0]    i_i_tile;
    logic [IDX_W-1:0]    i_j_tile;
    logic [IDX_W-1:0]    i_k_tile;
    logic [IDX_W-1:0]    i_etm;
    logic [IDX_W-1:0]    i_etn;
    logic [IDX_W-1:0]    i_etk;
    logic [IDX_W-1:0]    i_tm;
    logic [IDX_W-1:0]    i_tn;
    logic [IDX_W-1:0]    i_tk;
    logic [ADDR_W-1:0]   o_addr;
    stream_id_e          o_id;
    logic                o_valid;
    logic                o_is_null;
    logic                o_tile_done;
    logic                o_ready;

    // Current test setup
    op_mode_e            mode_r;
    tile_cfg_t           tcfg;
    conv_cfg_t           ccfg;
    logic [ADDR_W-1:0]   base_a;
    logic [ADDR_W-1:0]   base_b;
    logic [ADDR_W-1:0]   base_c;

    logic [15:0]         lfsr_state;
    logic [34:0]         exp_q[$];
    logic [34:0]         exp_e;
    logic                req_prev;
    string               cur_test;
    int                  err_cnt;
    int                  pass_cnt;
    int                  fail_cnt;

    conv_agu_top #(
        .ADDR_W (ADDR_W),
        .IDX_W  (IDX_W)
    ) u_conv_agu_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        int          b;
        bits = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = galois_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic logic next_req(input logic use_lfsr);
        logic [31:0] bits;
        if (!use_lfsr) begin
            return 1'b1;
        end
        bits = take_bits(1);
        return bits[0];
    endfunction

    task automatic new_bases();
        base_a = take_bits(12) << 4;
        base_b = take_bits(12) << 4;
        base_c = take_bits(12) << 4;
    endtask

    task automatic set_tile(input op_mode_e mode, input int it, input int jt, input int kt,
                            input int tm, input int tn, input int tk,
                            input int etm, input int etn, input int etk,
                            input int mk, input int mn);
        mode_r      = mode;
        tcfg.i_tile = it;
        tcfg.j_tile = jt;
        tcfg.k_tile = kt;
        tcfg.tm     = tm;
        tcfg.tn     = tn;
        tcfg.tk     = tk;
        tcfg.etm    = etm;
        tcfg.etn    = etn;
        tcfg.etk    = etk;
        tcfg.mat_k  = mk;
        tcfg.mat_n  = mn;
    endtask

    task automatic set_conv(input int h, input int w, input int cin, input int pad,
                            input int stride);
        ccfg.act_h   = h;
        ccfg.act_w   = w;
        ccfg.act_cin = cin;
        ccfg.padding = pad;
        ccfg.stride  = stride;
        ccfg.out_w   = (w + 2 * pad - 1) / stride + 1;
    endtask

    task automatic drive_config();
        i_op_mode <= mode_r;
        i_base_a  <= base_a;
        i_base_b  <= base_b;
        i_base_c  <= base_c;
        i_act_h   <= ccfg.act_h;
        i_act_w   <= ccfg.act_w;
        i_act_cin <= ccfg.act_cin;
        i_padding <= ccfg.padding;
        i_stride  <= ccfg.stride;
        i_mat_k   <= tcfg.mat_k;
        i_mat_n   <= tcfg.mat_n;
        i_i_tile  <= tcfg.i_tile;
        i_j_tile  <= tcfg.j_tile;
        i_k_tile  <= tcfg.k_tile;
        i_etm     <= tcfg.etm;
        i_etn     <= tcfg.etn;
        i_etk     <= tcfg.etk;
        i_tm      <= tcfg.tm;
        i_tn      <= tcfg.tn;
        i_tk      <= tcfg.tk;
    endtask

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_ready) begin
            $display("%s: o_ready still low after %0d cycles", name, READY_TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (!req_prev && o_valid) begin
                $display("ERROR %s: o_valid after low read request expected 0 actual %b",
                         cur_test, o_valid);
                err_cnt++;
            end
            if (o_tile_done && !o_valid) begin
                $display("ERROR %s: o_tile_done without o_valid expected 0 actual %b",
                         cur_test, o_tile_done);
                err_cnt++;
            end
            if (o_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: unexpected output %h with id %0d", cur_test, o_addr, o_id);
                    err_cnt++;
                end else begin
                    exp_e = exp_q.pop_front();
                    if (o_id !== exp_e[34:33]) begin
                        $display("ERROR %s: o_id expected %0d actual %0d",
                                 cur_test, exp_e[34:33], o_id);
                        err_cnt++;
                    end
                    if (o_addr !== exp_e[31:0]) begin
                        $display("ERROR %s: o_addr expected %h actual %h",
                                 cur_test, exp_e[31:0], o_addr);
                        err_cnt++;
                    end
                    if (o_is_null !== exp_e[32]) begin
                        $display("ERROR %s: o_is_null expected %b actual %b",
                                 cur_test, exp_e[32], o_is_null);
                        err_cnt++;
                    end
                    // Done must sit on the last C address and nowhere else
                    if (o_tile_done !== (exp_q.size() == 0)) begin
                        $display("ERROR %s: o_tile_done expected %b actual %b",
                                 cur_test, exp_q.size() == 0, o_tile_done);
                        err_cnt++;
                    end
                end
            end
        end
        req_prev = i_read_req;
    end

    // ------------------------------
    // One tile from start to done
    // ------------------------------
    task automatic run_tile(input string name, input logic use_lfsr);
        int   cycles;
        int   errs_before;
        int   p;
        logic seen_done;
        cur_test    = name;
        errs_before = err_cnt;
        exp_q.delete();
        for (p = 0; p < tcfg.tm * tcfg.tk; p++) begin
            exp_q.push_back({2'd0, ref_entry(mode_r, tcfg, ccfg, base_a, 0, p)});
        end
        for (p = 0; p < tcfg.tn * tcfg.tk; p++) begin
            exp_q.push_back({2'd1, ref_entry(mode_r, tcfg, ccfg, base_b, 1, p)});
        end
        for (p = 0; p < tcfg.tm * tcfg.tn; p++) begin
            exp_q.push_back({2'd2, ref_entry(mode_r, tcfg, ccfg, base_c, 2, p)});
        end
        wait_ready(name);
        @(posedge clk);
        drive_config();
        i_start_tile <= 1'b1;
        @(posedge clk);
        i_start_tile <= 1'b0;
        i_read_req   <= next_req(use_lfsr);
        cycles    = 0;
        seen_done = 1'b0;
        while (!seen_done && cycles < TILE_TIMEOUT) begin
            @(negedge clk);
            if (o_tile_done) begin
                seen_done = 1'b1;
            end else begin
                if (o_ready) begin
                    $display("ERROR %s: o_ready before tile done expected 0 actual %b",
                             name, o_ready);
                    err_cnt++;
                end
                @(posedge clk);
                i_read_req <= next_req(use_lfsr);
                cycles++;
            end
        end
        @(posedge clk);
        i_read_req <= 1'b0;
        @(negedge clk);
        if (!seen_done) begin
            $display("%s: timeout, no tile done within %0d cycles", name, TILE_TIMEOUT);
            err_cnt++;
        end else begin
            if (!o_ready) begin
                $display("ERROR %s: o_ready after tile done expected 1 actual %b",
                         name, o_ready);
                err_cnt++;
            end
            if (o_tile_done) begin
                $display("ERROR %s: o_tile_done after its pulse expected 0 actual %b",
                         name, o_tile_done);
                err_cnt++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected addresses never appeared", name, exp_q.size());
            err_cnt++;
        end
        report_test(name, errs_before);
    endtask

    task automatic check_reset();
        int errs_before;
        cur_test    = "reset_handshake";
        errs_before = err_cnt;
        wait_ready(cur_test);
        if (o_valid !== 1'b0) begin
            $display("ERROR %s: o_valid expected 0 actual %b", cur_test, o_valid);
            err_cnt++;
        end
        if (o_tile_done !== 1'b0) begin
            $display("ERROR %s: o_tile_done expected 0 actual %b", cur_test, o_tile_done);
            err_cnt++;
        end
        if (o_addr !== NULL_ADDR) begin
            $display("ERROR %s: o_addr expected %h actual %h", cur_test, NULL_ADDR, o_addr);
            err_cnt++;
        end
        if (o_is_null !== 1'b1) begin
            $display("ERROR %s: o_is_null expected 1 actual %b", cur_test, o_is_null);
            err_cnt++;
        end
        report_test(cur_test, errs_before);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        lfsr_state = 16'd45000;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        req_prev   = 1'b0;
        cur_test   = "reset";
        rst_n      = 1'b0;
        mode_r     = OP_MATMUL;
        tcfg       = '0;
        ccfg       = '0;
        base_a     = '0;
        base_b     = '0;
        base_c     = '0;
        i_start_tile <= 1'b0;
        i_read_req   <= 1'b0;
        drive_config();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        check_reset();

        new_bases();
        set_conv(1, 1, 1, 0, 1);
        set_tile(OP_MATMUL, 2, 4, 8, 3, 2, 4, 3, 2, 4, 16, 8);
        run_tile("mm_full", 1'b0);

        // Effective extents below nominal
        set_tile(OP_MATMUL, 1, 2, 0, 4, 3, 4, 2, 1, 3, 12, 6);
        run_tile("mm_partial", 1'b0);

        new_bases();
        set_conv(4, 5, 6, 1, 2);
        set_tile(OP_POINTWISE, 2, 1, 0, 8, 3, 6, 8, 3, 6, 0, 4);
        run_tile("pw_pad1_stride2", 1'b0);

        // Random gaps on read_req
        set_conv(1, 1, 1, 0, 1);
        set_tile(OP_MATMUL, 2, 4, 8, 3, 2, 4, 3, 2, 4, 16, 8);
        run_tile("mm_backpressure", 1'b1);

        // Two tiles in a row with new origins and a mode change
        new_bases();
        set_tile(OP_MATMUL, 4, 2, 0, 2, 3, 3, 2, 3, 3, 8, 8);
        run_tile("b2b_tile_mm", 1'b1);
        set_conv(6, 4, 5, 1, 2);
        set_tile(OP_POINTWISE, 6, 0, 2, 4, 2, 3, 3, 2, 3, 0, 2);
        run_tile("b2b_tile_pw", 1'b1);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
logic/agu_pkg.sv
logic/agu_stream_if.sv
logic/tile_idx_counter.sv
logic/act_addr_gen.sv
logic/ker_addr_gen.sv
logic/out_addr_gen.sv
logic/addr_port_arbiter.sv
logic/conv_agu_top.sv
verif/tb_conv_agu.sv
